// ==== link_concat_pkg.sv ====
// Shared channel geometry, strobe timing and channel word layout for the two-channel concat link
package link_concat_pkg;

  ////////////////////
  // Channel geometry
  ////////////////////

  // One PHY channel word at full rate
  localparam int CH_WIDTH      = 40;

  // Logic-link word, split over both channels
  localparam int DATA_WIDTH    = 75;

  // Usable data bits per channel
  localparam int CH_DATA_WIDTH = 38;

  // Userbit positions, same for every channel
  localparam int STROBE_LOC    = 1;
  localparam int MARKER_LOC    = 39;

  ////////////////////
  // Boundary flops
  ////////////////////

  // Set to 1 to register the channel words at the PHY edge
  localparam bit TX_REG_PHY    = 1'b1;
  localparam bit RX_REG_PHY    = 1'b1;

  ////////////////////
  // Strobe timing
  ////////////////////

  // Cycles from one strobe to the next
  localparam int STROBE_PERIOD = 8;

  // Consecutive good strobes before the link counts as aligned
  localparam int ALIGN_COUNT   = 3;

  // Violation counter width, saturates at all ones
  localparam int ERR_WIDTH     = 8;

  // Channel word, raw on the PHY and decoded by field inside the link
  typedef union packed {
    logic [CH_WIDTH-1:0] raw;
    struct packed {
      logic                             marker;
      logic [MARKER_LOC-STROBE_LOC-2:0] data_hi;
      logic                             strobe;
      logic [STROBE_LOC-1:0]            data_lo;
    } fields;
  } ch_word_u;

endpackage

// ==== tx_userbit_gen.sv ====
// Strobe and marker userbit source for the TX concat, enabled by the transmitter online level
`timescale 1ns/1ps

module tx_userbit_gen (
  input  logic clk_rd,
  input  logic rst_rd_n,
  input  logic tx_online,
  output logic stb_userbit,
  output logic mrk_userbit
);

  // Position within the strobe period, parked at zero while offline
  logic [$clog2(link_concat_pkg::STROBE_PERIOD)-1:0] stb_phase;
  logic                                              phase_wrap;

  assign phase_wrap = (stb_phase == link_concat_pkg::STROBE_PERIOD - 1);

  ////////////////////
  // Phase counter
  ////////////////////

  always_ff @(posedge clk_rd or negedge rst_rd_n)
  begin
    if (!rst_rd_n)
    begin
      stb_phase <= '0;
    end
    else if (!tx_online || phase_wrap)
    begin
      stb_phase <= '0;
    end
    else
    begin
      stb_phase <= stb_phase + 1'b1;
    end
  end

  ////////////////////
  // Userbit outputs
  ////////////////////

  // Strobe pulse for phase zero shows up one cycle later,
  // so the first one follows the rising edge of tx_online
  always_ff @(posedge clk_rd or negedge rst_rd_n)
  begin
    if (!rst_rd_n)
    begin
      stb_userbit <= 1'b0;
      mrk_userbit <= 1'b0;
    end
    else
    begin
      stb_userbit <= tx_online && (stb_phase == '0);
      mrk_userbit <= tx_online;  // marker is a persistent level
    end
  end

endmodule

// ==== tx_concat.sv ====
// TX side of the link, maps the 75-bit downstream word and userbits onto two PHY channel words
`timescale 1ns/1ps

module tx_concat (
  input  logic                                   clk_rd,
  input  logic                                   rst_rd_n,
  input  logic [link_concat_pkg::DATA_WIDTH-1:0] tx_downstream_data,
  input  logic                                   stb_userbit,
  input  logic                                   mrk_userbit,
  output logic [link_concat_pkg::CH_WIDTH-1:0]   tx_phy0,
  output logic [link_concat_pkg::CH_WIDTH-1:0]   tx_phy1
);

  // Per-channel data slices
  logic [link_concat_pkg::CH_DATA_WIDTH-1:0] ch0_slice;
  logic [link_concat_pkg::CH_DATA_WIDTH-1:0] ch1_slice;

  // Channel words before and after the boundary flop
  link_concat_pkg::ch_word_u tx_word0;
  link_concat_pkg::ch_word_u tx_word1;
  link_concat_pkg::ch_word_u tx_flop0;
  link_concat_pkg::ch_word_u tx_flop1;

  // Lowest slice bit sits under the strobe, the rest between strobe and marker
  function automatic link_concat_pkg::ch_word_u pack_word(
    input logic [link_concat_pkg::CH_DATA_WIDTH-1:0] slice,
    input logic                                      stb,
    input logic                                      mrk
  );
    link_concat_pkg::ch_word_u word;
    word.fields.marker  = mrk;
    word.fields.data_hi = slice[link_concat_pkg::CH_DATA_WIDTH-1:link_concat_pkg::STROBE_LOC];
    word.fields.strobe  = stb;
    word.fields.data_lo = slice[link_concat_pkg::STROBE_LOC-1:0];
    return word;
  endfunction

  ////////////////////
  // Word mapping
  ////////////////////

  assign ch0_slice = tx_downstream_data[link_concat_pkg::CH_DATA_WIDTH-1:0];

  // Channel 1 is one bit short, the spare on top stays zero
  assign ch1_slice = {1'b0,
                      tx_downstream_data[link_concat_pkg::DATA_WIDTH-1:
                                         link_concat_pkg::CH_DATA_WIDTH]};

  assign tx_word0 = pack_word(ch0_slice, stb_userbit, mrk_userbit);
  assign tx_word1 = pack_word(ch1_slice, stb_userbit, mrk_userbit);

  ////////////////////
  // Boundary flop
  ////////////////////

  always_ff @(posedge clk_rd or negedge rst_rd_n)
  begin
    if (!rst_rd_n)
    begin
      tx_flop0 <= '0;
      tx_flop1 <= '0;
    end
    else
    begin
      tx_flop0 <= tx_word0;
      tx_flop1 <= tx_word1;
    end
  end

  assign tx_phy0 = link_concat_pkg::TX_REG_PHY ? tx_flop0.raw : tx_word0.raw;
  assign tx_phy1 = link_concat_pkg::TX_REG_PHY ? tx_flop1.raw : tx_word1.raw;

endmodule

// ==== rx_split.sv ====
// RX side of the link, registers both PHY channel words and joins their data into the upstream word
`timescale 1ns/1ps

module rx_split (
  input  logic                                   clk_rd,
  input  logic                                   rst_rd_n,
  input  logic [link_concat_pkg::CH_WIDTH-1:0]   rx_phy0,
  input  logic [link_concat_pkg::CH_WIDTH-1:0]   rx_phy1,
  output logic [link_concat_pkg::DATA_WIDTH-1:0] rx_upstream_data,
  output link_concat_pkg::ch_word_u              rx_ch0,
  output link_concat_pkg::ch_word_u              rx_ch1
);

  // Boundary flop contents
  logic [link_concat_pkg::CH_WIDTH-1:0] rx_flop0;
  logic [link_concat_pkg::CH_WIDTH-1:0] rx_flop1;

  // Data bits of each channel with the userbits stripped
  logic [link_concat_pkg::CH_DATA_WIDTH-1:0] rx_slice0;
  logic [link_concat_pkg::CH_DATA_WIDTH-1:0] rx_slice1;

  ////////////////////
  // Boundary flop
  ////////////////////

  always_ff @(posedge clk_rd or negedge rst_rd_n)
  begin
    if (!rst_rd_n)
    begin
      rx_flop0 <= '0;
      rx_flop1 <= '0;
    end
    else
    begin
      rx_flop0 <= rx_phy0;
      rx_flop1 <= rx_phy1;
    end
  end

  // Same words also feed the alignment monitor
  assign rx_ch0 = link_concat_pkg::RX_REG_PHY ? rx_flop0 : rx_phy0;
  assign rx_ch1 = link_concat_pkg::RX_REG_PHY ? rx_flop1 : rx_phy1;

  ////////////////////
  // Data join
  ////////////////////

  // Strobe and marker fall out of the field view
  assign rx_slice0 = {rx_ch0.fields.data_hi, rx_ch0.fields.data_lo};
  assign rx_slice1 = {rx_ch1.fields.data_hi, rx_ch1.fields.data_lo};

  // Top bit of channel 1 is the spare and is not part of the word
  assign rx_upstream_data = {
    rx_slice1[link_concat_pkg::DATA_WIDTH-link_concat_pkg::CH_DATA_WIDTH-1:0],
    rx_slice0
  };

endmodule

// ==== rx_align_monitor.sv ====
// Receive alignment monitor, checks strobe spacing and markers on both channels and counts faults
`timescale 1ns/1ps

module rx_align_monitor (
  input  logic                                  clk_rd,
  input  logic                                  rst_rd_n,
  input  link_concat_pkg::ch_word_u             rx_ch0,
  input  link_concat_pkg::ch_word_u             rx_ch1,
  output logic                                  rx_aligned,
  output logic [link_concat_pkg::ERR_WIDTH-1:0] rx_align_err
);

  // Decoded userbits
  logic stb0;
  logic stb1;
  logic mrk0;
  logic mrk1;

  // Per-cycle checks
  logic both_stb;
  logic stb_mismatch;
  logic spacing_err;
  logic mrk_missing;
  logic mrk_loss;
  logic link_down;
  logic violation;
  logic good_stb;

  // Spacing reference and good-strobe run
  logic                                                   stb_seen;
  logic [$clog2(link_concat_pkg::STROBE_PERIOD+2)-1:0]    gap_cnt;
  logic [$clog2(link_concat_pkg::ALIGN_COUNT+1)-1:0]      good_run;

  assign stb0 = rx_ch0.fields.strobe;
  assign stb1 = rx_ch1.fields.strobe;
  assign mrk0 = rx_ch0.fields.marker;
  assign mrk1 = rx_ch1.fields.marker;

  ////////////////////
  // Checks
  ////////////////////

  assign both_stb     = stb0 && stb1;
  assign stb_mismatch = stb0 ^ stb1;
  assign spacing_err  = both_stb && stb_seen && (gap_cnt != link_concat_pkg::STROBE_PERIOD);
  assign mrk_missing  = (stb0 || stb1) && !(mrk0 && mrk1);

  // Both markers gone means the far transmitter went offline
  assign link_down    = !mrk0 && !mrk1;
  assign mrk_loss     = link_down && rx_aligned;

  assign violation    = stb_mismatch || spacing_err || mrk_missing || mrk_loss;
  assign good_stb     = both_stb && !violation;

  ////////////////////
  // Strobe tracking
  ////////////////////

  // gap_cnt holds the cycles since the last good strobe, saturating one past the period.
  // A fault or a lost link drops the reference, so the next strobe starts a new run
  always_ff @(posedge clk_rd or negedge rst_rd_n)
  begin
    if (!rst_rd_n)
    begin
      gap_cnt    <= '0;
      stb_seen   <= 1'b0;
      good_run   <= '0;
      rx_aligned <= 1'b0;
    end
    else
    begin
      if (good_stb)
        gap_cnt <= 1;
      else if (gap_cnt != link_concat_pkg::STROBE_PERIOD + 1)
        gap_cnt <= gap_cnt + 1'b1;

      if (violation || link_down)
      begin
        stb_seen   <= 1'b0;
        good_run   <= '0;
        rx_aligned <= 1'b0;
      end
      else if (good_stb)
      begin
        stb_seen <= 1'b1;
        if (good_run != link_concat_pkg::ALIGN_COUNT)
          good_run <= good_run + 1'b1;
        // Rises in the cycle after the run completes
        if (good_run >= link_concat_pkg::ALIGN_COUNT - 1)
          rx_aligned <= 1'b1;
      end
    end
  end

  ////////////////////
  // Violation count
  ////////////////////

  always_ff @(posedge clk_rd or negedge rst_rd_n)
  begin
    if (!rst_rd_n)
    begin
      rx_align_err <= '0;
    end
    else if (violation && !(&rx_align_err))
    begin
      rx_align_err <= rx_align_err + 1'b1;
    end
  end

endmodule

// ==== link_concat_top.sv ====
// Top level of the two-channel concat link, ties the userbit source, TX, RX and monitor together
`timescale 1ns/1ps

module link_concat_top (
  input  logic                                   clk_rd,
  input  logic                                   rst_rd_n,
  input  logic                                   tx_online,
  input  logic [link_concat_pkg::DATA_WIDTH-1:0] tx_downstream_data,
  output logic [link_concat_pkg::CH_WIDTH-1:0]   tx_phy0,
  output logic [link_concat_pkg::CH_WIDTH-1:0]   tx_phy1,
  input  logic [link_concat_pkg::CH_WIDTH-1:0]   rx_phy0,
  input  logic [link_concat_pkg::CH_WIDTH-1:0]   rx_phy1,
  output logic [link_concat_pkg::DATA_WIDTH-1:0] rx_upstream_data,
  output logic                                   rx_aligned,
  output logic [link_concat_pkg::ERR_WIDTH-1:0]  rx_align_err
);

  // Userbits toward the TX mapping
  logic stb_userbit;
  logic mrk_userbit;

  // Registered RX channel words toward the monitor
  link_concat_pkg::ch_word_u rx_ch0;
  link_concat_pkg::ch_word_u rx_ch1;

  ////////////////////
  // TX path
  ////////////////////

  tx_userbit_gen i_tx_userbit_gen (
    .clk_rd      (clk_rd),
    .rst_rd_n    (rst_rd_n),
    .tx_online   (tx_online),
    .stb_userbit (stb_userbit),
    .mrk_userbit (mrk_userbit)
  );

  tx_concat i_tx_concat (
    .clk_rd             (clk_rd),
    .rst_rd_n           (rst_rd_n),
    .tx_downstream_data (tx_downstream_data),
    .stb_userbit        (stb_userbit),
    .mrk_userbit        (mrk_userbit),
    .tx_phy0            (tx_phy0),
    .tx_phy1            (tx_phy1)
  );

  ////////////////////
  // RX path
  ////////////////////

  rx_split i_rx_split (
    .clk_rd           (clk_rd),
    .rst_rd_n         (rst_rd_n),
    .rx_phy0          (rx_phy0),
    .rx_phy1          (rx_phy1),
    .rx_upstream_data (rx_upstream_data),
    .rx_ch0           (rx_ch0),
    .rx_ch1           (rx_ch1)
  );

  rx_align_monitor i_rx_align_monitor (
    .clk_rd       (clk_rd),
    .rst_rd_n     (rst_rd_n),
    .rx_ch0       (rx_ch0),
    .rx_ch1       (rx_ch1),
    .rx_aligned   (rx_aligned),
    .rx_align_err (rx_align_err)
  );

endmodule

// ==== link_concat_tb.sv ====
// Self-checking testbench for link_concat_top, runs a PHY loopback with strobe fault injection
`timescale 1ns/1ps

module link_concat_tb;

  localparam int ALIGN_BOUND = (link_concat_pkg::ALIGN_COUNT + 2) * link_concat_pkg::STROBE_PERIOD;

  // DUT ports
  logic                                   clk_rd;
  logic                                   rst_rd_n;
  logic                                   tx_online;
  logic [link_concat_pkg::DATA_WIDTH-1:0] tx_downstream_data = '0;
  logic [link_concat_pkg::CH_WIDTH-1:0]   tx_phy0;
  logic [link_concat_pkg::CH_WIDTH-1:0]   tx_phy1;
  logic [link_concat_pkg::CH_WIDTH-1:0]   rx_phy0;
  logic [link_concat_pkg::CH_WIDTH-1:0]   rx_phy1;
  logic [link_concat_pkg::DATA_WIDTH-1:0] rx_upstream_data;
  logic                                   rx_aligned;
  logic [link_concat_pkg::ERR_WIDTH-1:0]  rx_align_err;

  // Loopback fault control
  logic                                   inject;
  logic [link_concat_pkg::CH_WIDTH-1:0]   strobe_flip;

  // Expected-value history, one entry per cycle
  logic [link_concat_pkg::DATA_WIDTH-1:0] data_d1;
  logic [link_concat_pkg::DATA_WIDTH-1:0] data_d2;
  logic                                   on_d1, on_d2, on_d3, on_d4, on_d5;
  logic                                   inj_d1, inj_d2;
  logic [link_concat_pkg::ERR_WIDTH-1:0]  exp_err;
  logic                                   rst_d1;
  logic                                   tx_seen;
  int                                     tx_gap;
  logic                                   hold_aligned;
  logic                                   fault_due;

  integer seed = 78830;
  int     error_count = 0;
  int     timeout_count = 0;
  int     checked_words = 0;
  int     skip;

  link_concat_top i_link_concat_top (
    .clk_rd             (clk_rd),
    .rst_rd_n           (rst_rd_n),
    .tx_online          (tx_online),
    .tx_downstream_data (tx_downstream_data),
    .tx_phy0            (tx_phy0),
    .tx_phy1            (tx_phy1),
    .rx_phy0            (rx_phy0),
    .rx_phy1            (rx_phy1),
    .rx_upstream_data   (rx_upstream_data),
    .rx_aligned         (rx_aligned),
    .rx_align_err       (rx_align_err)
  );

  ////////////////////
  // Clock and loopback
  ////////////////////

  initial
  begin
    clk_rd = 1'b0;
    forever #4 clk_rd = ~clk_rd;
  end

  // Fault flips only the strobe of channel 1
  assign strobe_flip = {{(link_concat_pkg::CH_WIDTH-link_concat_pkg::STROBE_LOC-1){1'b0}},
                        inject, {link_concat_pkg::STROBE_LOC{1'b0}}};
  assign rx_phy0 = tx_phy0;
  assign rx_phy1 = tx_phy1 ^ strobe_flip;

  ////////////////////
  // Helpers
  ////////////////////

  function automatic logic [link_concat_pkg::DATA_WIDTH-1:0] next_word();
    logic [95:0] r;
    r = {$random(seed), $random(seed), $random(seed)};
    return r[link_concat_pkg::DATA_WIDTH-1:0];
  endfunction

  // Channel data bits with strobe and marker removed
  function automatic logic [link_concat_pkg::CH_DATA_WIDTH-1:0] channel_data(
    input logic [link_concat_pkg::CH_WIDTH-1:0] w
  );
    return {w[link_concat_pkg::MARKER_LOC-1:link_concat_pkg::STROBE_LOC+1],
            w[link_concat_pkg::STROBE_LOC-1:0]};
  endfunction

  task automatic report_error(input string msg);
    $display("[ERROR] %0t: %s", $time, msg);
    error_count++;
  endtask

  task automatic wait_aligned_level(input logic level, input int limit, input string what);
    int  n;
    bit  seen;
    n    = 0;
    seen = 1'b0;
    while (!seen && n < limit)
    begin
      @(posedge clk_rd);
      n++;
      if (rx_aligned == level)
        seen = 1'b1;
    end
    if (!seen)
    begin
      timeout_count++;
      $display("Timeout at %0t: %s did not happen within %0d cycles", $time, what, limit);
    end
  endtask

  ////////////////////
  // Data driver and reference history
  ////////////////////

  always @(posedge clk_rd)
  begin
    if (rst_rd_n)
      tx_downstream_data <= next_word();
    else
      tx_downstream_data <= '0;
  end

  always @(posedge clk_rd or negedge rst_rd_n)
  begin
    if (!rst_rd_n)
    begin
      data_d1    <= '0;
      data_d2    <= '0;
      {on_d1, on_d2, on_d3, on_d4, on_d5} <= '0;
      inj_d1     <= 1'b0;
      inj_d2     <= 1'b0;
      exp_err    <= '0;
      rst_d1     <= 1'b0;
      tx_seen    <= 1'b0;
      tx_gap     <= 0;
    end
    else
    begin
      data_d1    <= tx_downstream_data;
      data_d2    <= data_d1;
      {on_d1, on_d2, on_d3, on_d4, on_d5} <= {tx_online, on_d1, on_d2, on_d3, on_d4};
      inj_d1     <= inject;
      inj_d2     <= inj_d1;
      rst_d1     <= 1'b1;
      checked_words <= checked_words + 1;
      // One count per injected mismatch and per marker loss
      if (inj_d1 || (on_d4 && !on_d3))
        exp_err <= exp_err + 1'b1;
      // Strobe spacing seen at the TX PHY
      if (!on_d2)
      begin
        tx_seen <= 1'b0;
        tx_gap  <= 0;
      end
      else if (tx_phy0[link_concat_pkg::STROBE_LOC])
      begin
        tx_seen <= 1'b1;
        tx_gap  <= 1;
      end
      else
        tx_gap <= tx_gap + 1;
    end
  end

  // Injected mismatch or marker loss, visible at the monitor 3 or 5 cycles on
  assign fault_due = inj_d2 || (on_d5 && !on_d4);

  ////////////////////
  // Checks
  ////////////////////

  chk_reset: assert property (@(posedge clk_rd) !rst_d1 |->
    (tx_phy0 == '0 && tx_phy1 == '0 && rx_upstream_data == '0 &&
     !rx_aligned && rx_align_err == '0))
    else report_error("outputs not at reset values");

  chk_ch0_data: assert property (@(posedge clk_rd) disable iff (!rst_rd_n)
    channel_data(tx_phy0) == data_d1[link_concat_pkg::CH_DATA_WIDTH-1:0])
    else report_error("tx_phy0 data bits differ from the downstream word");

  chk_ch1_data: assert property (@(posedge clk_rd) disable iff (!rst_rd_n)
    channel_data(tx_phy1) ==
      {1'b0, data_d1[link_concat_pkg::DATA_WIDTH-1:link_concat_pkg::CH_DATA_WIDTH]})
    else report_error("tx_phy1 data bits differ from the downstream word");

  chk_spare: assert property (@(posedge clk_rd) disable iff (!rst_rd_n)
    tx_phy1[link_concat_pkg::MARKER_LOC-1] == 1'b0)
    else report_error("tx_phy1 spare bit is not zero");

  chk_marker: assert property (@(posedge clk_rd) disable iff (!rst_rd_n)
    tx_phy0[link_concat_pkg::MARKER_LOC] == on_d2 &&
    tx_phy1[link_concat_pkg::MARKER_LOC] == on_d2)
    else report_error("marker bits do not follow tx_online");

  chk_loopback: assert property (@(posedge clk_rd) disable iff (!rst_rd_n)
    rx_upstream_data == data_d2)
    else report_error("rx_upstream_data differs from the word driven two cycles earlier");

  chk_stb_equal: assert property (@(posedge clk_rd) disable iff (!rst_rd_n)
    tx_phy0[link_concat_pkg::STROBE_LOC] == tx_phy1[link_concat_pkg::STROBE_LOC])
    else report_error("strobe bits differ between the TX channels");

  chk_stb_offline: assert property (@(posedge clk_rd) disable iff (!rst_rd_n)
    !on_d2 |-> !tx_phy0[link_concat_pkg::STROBE_LOC])
    else report_error("strobe sent while offline");

  chk_stb_first: assert property (@(posedge clk_rd) disable iff (!rst_rd_n)
    (on_d2 && !on_d3) |-> tx_phy0[link_concat_pkg::STROBE_LOC])
    else report_error("no strobe right after tx_online rose");

  chk_stb_period: assert property (@(posedge clk_rd) disable iff (!rst_rd_n)
    (on_d2 && tx_seen) |->
      (tx_phy0[link_concat_pkg::STROBE_LOC] == (tx_gap == link_concat_pkg::STROBE_PERIOD)))
    else report_error("strobe spacing is not STROBE_PERIOD");

  chk_hold: assert property (@(posedge clk_rd) disable iff (!rst_rd_n)
    hold_aligned |-> rx_aligned)
    else report_error("rx_aligned dropped without a fault");

  chk_err_count: assert property (@(posedge clk_rd) disable iff (!rst_rd_n)
    rx_align_err == exp_err)
    else report_error("rx_align_err differs from the number of faults");

  chk_fault_drop: assert property (@(posedge clk_rd) disable iff (!rst_rd_n)
    fault_due |-> !rx_aligned)
    else report_error("rx_aligned did not drop after a fault");

  ////////////////////
  // Stimulus
  ////////////////////

  initial
  begin
    rst_rd_n     = 1'b0;
    tx_online    = 1'b0;
    inject       = 1'b0;
    hold_aligned = 1'b0;
    repeat (10) @(posedge clk_rd);
    rst_rd_n <= 1'b1;
    repeat (5) @(posedge clk_rd);

    // Bring the link up
    tx_online <= 1'b1;
    wait_aligned_level(1'b1, ALIGN_BOUND, "alignment after tx_online rose");
    hold_aligned <= 1'b1;
    repeat (40) @(posedge clk_rd);

    // Single-cycle strobe mismatch at a random phase
    repeat (3)
    begin
      skip = 1 + (($random(seed) & 32'h7fff_ffff) % link_concat_pkg::STROBE_PERIOD);
      repeat (skip) @(posedge clk_rd);
      hold_aligned <= 1'b0;
      inject       <= 1'b1;
      @(posedge clk_rd);
      inject <= 1'b0;
      wait_aligned_level(1'b0, 8, "alignment loss after a strobe mismatch");
      wait_aligned_level(1'b1, ALIGN_BOUND, "realignment after a strobe mismatch");
      hold_aligned <= 1'b1;
      repeat (20) @(posedge clk_rd);
    end

    // Transmitter offline, then back
    hold_aligned <= 1'b0;
    tx_online    <= 1'b0;
    wait_aligned_level(1'b0, 10, "alignment loss after tx_online fell");
    repeat (20) @(posedge clk_rd);
    tx_online <= 1'b1;
    wait_aligned_level(1'b1, ALIGN_BOUND, "realignment after tx_online rose again");
    hold_aligned <= 1'b1;
    repeat (30) @(posedge clk_rd);

    $display("Summary: %0d errors, %0d timeouts, %0d cycles checked",
             error_count, timeout_count, checked_words);
    if (error_count == 0 && timeout_count == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

endmodule

// ==== sim.f ====
link_concat_pkg.sv
tx_userbit_gen.sv
tx_concat.sv
rx_split.sv
rx_align_monitor.sv
link_concat_top.sv
link_concat_tb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the link_concat testbench with Verilator, runs it and checks for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  -f sim.f \
  --top-module link_concat_tb \
  -o link_concat_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/link_concat_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "NO ERRORS"; then
  exit 0
fi

echo "Pass line not found in simulation output"
exit 1
